/* src/i2s_tx_params.svh */
`ifndef I2S_TX_PARAMS_SVH
`define I2S_TX_PARAMS_SVH

// apb register byte offsets
`define I2S_REG_ENABLE   8'h00  // core enable, any nonzero value
`define I2S_REG_FIFO     8'h04  // audio word push, write only
`define I2S_REG_CLKDIV   8'h08  // mclk cycles per sclk half period
`define I2S_REG_BITS     8'h0C  // sample width, 16/24/32
`define I2S_REG_FIFO_RST 8'h10  // nonzero write flushes the fifo
`define I2S_REG_STATUS   8'h14  // read clears the irq enable
`define I2S_REG_IRQ_PEND 8'h18  // registered irq condition
`define I2S_REG_IRQ_EN   8'h20  // fifo not-full interrupt enable

// sample fifo size in words, keep a power of two
`define I2S_FIFO_DEPTH 8

// reset defaults
`define I2S_CLKDIV_RST 16'd2  // sclk = mclk / 4
`define I2S_BITS_RST   6'd32

`endif

/* src/i2s_tx_pkg.sv */
`default_nettype none

package i2s_tx_pkg;

  // bus side
  typedef logic [7:0]  apb_addr_t;  // register offset
  typedef logic [31:0] apb_data_t;  // apb data word

  // audio side
  typedef logic [31:0] sample_t;       // one channel word, low bits used
  typedef logic [15:0] clk_div_t;      // mclk cycles per sclk half period
  typedef logic [5:0]  sample_bits_t;  // width, also the bit counter
  typedef logic [3:0]  fifo_cnt_t;     // 0..depth, needs one bit over the pointer

  // serializer frame states
  // lrclk low in left, high in right and idle
  typedef enum logic [1:0] {
    TX_IDLE  = 2'b00,
    TX_LEFT  = 2'b01,
    TX_RIGHT = 2'b10
  } tx_state_e;

endpackage

`default_nettype wire

/* src/i2s_apb_regs.sv */
`timescale 1ns/100ps
`default_nettype none
`include "i2s_tx_params.svh"

module i2s_apb_regs import i2s_tx_pkg::*; (
  input  logic         aud_mclk,
  input  logic         PRESETn,
  input  logic         PSEL,
  input  logic         PENABLE,
  input  logic         PWRITE,
  input  apb_addr_t    PADDR,
  input  apb_data_t    PWDATA,
  input  logic         full,        // fifo level
  input  logic         empty,       // fifo level
  input  logic         tx_idle,     // serializer parked
  output apb_data_t    PRDATA,
  output logic         irq,
  output logic         enable,
  output clk_div_t     clk_div,
  output sample_bits_t sample_bits,
  output logic         fifo_wr,
  output sample_t      fifo_wdata,
  output logic         fifo_flush
);

  logic      wr_acc;       // write access phase, commit point
  logic      rd_setup;     // read setup phase, prdata loads here
  logic      irq_en;
  logic      irq_pend;
  logic      tx_complete;
  logic      bits_ok;
  clk_div_t  wr_div;
  apb_data_t rd_mux;

  assign wr_acc   = PSEL & PENABLE & PWRITE;
  assign rd_setup = PSEL & ~PENABLE & ~PWRITE;

  assign tx_complete = tx_idle & empty;  // nothing queued, nothing on the wire

  // only the three standard widths are taken
  assign bits_ok = (PWDATA == 32'd16) || (PWDATA == 32'd24) || (PWDATA == 32'd32);
  assign wr_div  = clk_div_t'(PWDATA);

  // irq while software still has room to push
  assign irq = irq_en & enable & ~full;

  always_ff @(posedge aud_mclk or negedge PRESETn) begin
    if (!PRESETn) begin
      enable      <= 1'b0;
      clk_div     <= `I2S_CLKDIV_RST;
      sample_bits <= `I2S_BITS_RST;
      irq_en      <= 1'b0;
      irq_pend    <= 1'b0;
      fifo_wr     <= 1'b0;
      fifo_flush  <= 1'b0;
    end else begin
      irq_pend   <= irq;  // pending flop, one cycle behind irq
      fifo_wr    <= wr_acc && (PADDR == `I2S_REG_FIFO) && !full;  // dropped when full
      fifo_flush <= wr_acc && (PADDR == `I2S_REG_FIFO_RST) && (PWDATA != '0);

      if (wr_acc) begin
        case (PADDR)
          `I2S_REG_ENABLE: enable <= (PWDATA != '0);
          `I2S_REG_CLKDIV: begin
            if (wr_div != '0) begin  // zero would stall sclk, keep old
              clk_div <= wr_div;
            end
          end
          `I2S_REG_BITS: begin
            if (bits_ok) begin
              sample_bits <= sample_bits_t'(PWDATA);
            end
          end
          `I2S_REG_IRQ_EN: irq_en <= (PWDATA != '0);
          default: ;
        endcase
      end

      // reading status acks the interrupt by dropping its enable
      if (rd_setup && (PADDR == `I2S_REG_STATUS)) begin
        irq_en <= 1'b0;
      end
    end
  end

  // fifo payload
  always_ff @(posedge aud_mclk) begin
    if (wr_acc && (PADDR == `I2S_REG_FIFO)) begin
      fifo_wdata <= sample_t'(PWDATA);
    end
  end

  always_comb begin
    case (PADDR)
      `I2S_REG_ENABLE:   rd_mux = {31'b0, enable};
      `I2S_REG_CLKDIV:   rd_mux = {16'b0, clk_div};
      `I2S_REG_BITS:     rd_mux = {26'b0, sample_bits};
      // tx_complete, full, not-full, full
      `I2S_REG_STATUS:   rd_mux = {28'b0, tx_complete, full, ~full, full};
      `I2S_REG_IRQ_PEND: rd_mux = {31'b0, irq_pend};
      `I2S_REG_IRQ_EN:   rd_mux = {31'b0, irq_en};
      default:           rd_mux = '0;  // fifo and flush ports read zero
    endcase
  end

  // valid in the access phase, zero otherwise
  always_ff @(posedge aud_mclk or negedge PRESETn) begin
    if (!PRESETn) begin
      PRDATA <= '0;
    end else begin
      PRDATA <= rd_setup ? rd_mux : '0;
    end
  end

  // full updates one cycle after a push, and apb accesses are two cycles apart
  a_no_push_when_full: assert property (@(posedge aud_mclk) disable iff (!PRESETn)
    fifo_wr |-> !full);

endmodule

`default_nettype wire

/* src/i2s_sample_fifo.sv */
`timescale 1ns/100ps
`default_nettype none
`include "i2s_tx_params.svh"

module i2s_sample_fifo import i2s_tx_pkg::*; (
  input  logic    aud_mclk,
  input  logic    PRESETn,
  input  logic    wr,
  input  sample_t wdata,
  input  logic    pop,
  input  logic    flush,   // sync clear of all pointers
  output sample_t head,    // oldest word, show-ahead
  output logic    full,
  output logic    empty
);

  localparam int DEPTH = `I2S_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  typedef logic [AW-1:0] ptr_t;

  sample_t   mem [DEPTH];
  ptr_t      wr_ptr;
  ptr_t      rd_ptr;
  fifo_cnt_t cnt;
  logic      do_wr;
  logic      do_pop;

  assign full  = (cnt == fifo_cnt_t'(DEPTH));
  assign empty = (cnt == '0);

  assign do_wr  = wr & ~full;    // guarded anyway
  assign do_pop = pop & ~empty;

  assign head = mem[rd_ptr];

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge aud_mclk or negedge PRESETn) begin
    if (!PRESETn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else if (flush) begin
      wr_ptr <= '0;  // flush beats a same-cycle push
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + ptr_t'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end
      case ({do_wr, do_pop})
        2'b10:   cnt <= cnt + fifo_cnt_t'(1);
        2'b01:   cnt <= cnt - fifo_cnt_t'(1);
        default: cnt <= cnt;  // both or neither
      endcase
    end
  end

  always_ff @(posedge aud_mclk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wdata;
    end
  end

  a_no_pop_empty: assert property (@(posedge aud_mclk) disable iff (!PRESETn)
    pop |-> !empty);

  a_no_wr_full: assert property (@(posedge aud_mclk) disable iff (!PRESETn)
    wr |-> !full);

endmodule

`default_nettype wire

/* src/i2s_bclk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module i2s_bclk_gen import i2s_tx_pkg::*; (
  input  logic     aud_mclk,
  input  logic     PRESETn,
  input  logic     enable,
  input  clk_div_t clk_div,   // half period in mclk cycles, never zero
  output logic     sclk_out,
  output logic     bit_tick   // cycle after the sclk falling edge
);

  clk_div_t div_cnt;
  logic     sclk;
  logic     div_wrap;

  // >= so a smaller divider written mid-count still wraps
  assign div_wrap = (div_cnt >= clk_div - clk_div_t'(1));

  assign sclk_out = sclk & enable;

  always_ff @(posedge aud_mclk or negedge PRESETn) begin
    if (!PRESETn) begin
      div_cnt  <= '0;
      sclk     <= 1'b0;
      bit_tick <= 1'b0;
    end else if (!enable) begin
      // parked low, so the first edge after enable is a clean rise
      div_cnt  <= '0;
      sclk     <= 1'b0;
      bit_tick <= 1'b0;
    end else begin
      bit_tick <= sclk & div_wrap;  // sclk about to fall
      if (div_wrap) begin
        div_cnt <= '0;
        sclk    <= ~sclk;
      end else begin
        div_cnt <= div_cnt + clk_div_t'(1);
      end
    end
  end

  // serializer counts one bit per tick
  a_tick_single: assert property (@(posedge aud_mclk) disable iff (!PRESETn)
    bit_tick |=> !bit_tick);

endmodule

`default_nettype wire

/* src/i2s_serializer.sv */
`timescale 1ns/100ps
`default_nettype none

module i2s_serializer import i2s_tx_pkg::*; (
  input  logic         aud_mclk,
  input  logic         PRESETn,
  input  logic         enable,
  input  logic         bit_tick,
  input  sample_bits_t sample_bits,
  input  sample_t      head,       // fifo show-ahead word
  input  logic         empty,
  output logic         pop,
  output logic         lrclk_out,
  output logic         sdata_out,
  output logic         tx_idle
);

  tx_state_e    state;
  sample_t      shreg;      // remaining bits, next one at [31]
  sample_t      aligned;    // head with its msb moved up to bit 31
  sample_bits_t bit_cnt;    // bits already sent of the current word
  logic         word_done;
  logic         load;

  assign aligned   = head << (sample_bits_t'(32) - sample_bits);
  assign word_done = (bit_cnt >= sample_bits);

  // take a new word from idle or at the end of one
  assign load = !empty && ((state == TX_IDLE) || word_done);
  assign pop  = enable & bit_tick & load;

  assign tx_idle = (state == TX_IDLE);

  always_ff @(posedge aud_mclk or negedge PRESETn) begin
    if (!PRESETn) begin
      state     <= TX_IDLE;
      lrclk_out <= 1'b1;
      sdata_out <= 1'b0;
      bit_cnt   <= '0;
    end else if (!enable) begin
      state     <= TX_IDLE;  // disabled core restarts on the left channel
      lrclk_out <= 1'b1;
      sdata_out <= 1'b0;
      bit_cnt   <= '0;
    end else if (bit_tick) begin
      case (state)
        TX_IDLE: begin
          if (load) begin
            state     <= TX_LEFT;
            lrclk_out <= 1'b0;
            sdata_out <= aligned[31];  // msb with the lrclk edge
            bit_cnt   <= sample_bits_t'(1);
          end else begin
            sdata_out <= 1'b0;
          end
        end
        TX_LEFT, TX_RIGHT: begin
          if (!word_done) begin
            sdata_out <= shreg[31];
            bit_cnt   <= bit_cnt + sample_bits_t'(1);
          end else if (load) begin
            // back to back, swap channel
            state     <= (state == TX_LEFT) ? TX_RIGHT : TX_LEFT;
            lrclk_out <= (state == TX_LEFT);
            sdata_out <= aligned[31];
            bit_cnt   <= sample_bits_t'(1);
          end else begin
            state     <= TX_IDLE;  // underrun, park
            lrclk_out <= 1'b1;
            sdata_out <= 1'b0;
            bit_cnt   <= '0;
          end
        end
        default: begin
          state     <= TX_IDLE;
          lrclk_out <= 1'b1;
          sdata_out <= 1'b0;
          bit_cnt   <= '0;
        end
      endcase
    end
  end

  // shift path, msb already left on load
  always_ff @(posedge aud_mclk) begin
    if (enable && bit_tick) begin
      if (load) begin
        shreg <= aligned << 1;
      end else begin
        shreg <= shreg << 1;
      end
    end
  end

  // a popped word always opens a frame with its msb on the wire
  a_pop_starts_word: assert property (@(posedge aud_mclk) disable iff (!PRESETn)
    pop |=> !tx_idle && (bit_cnt == sample_bits_t'(1)));

endmodule

`default_nettype wire

/* src/i2s_transmitter.sv */
`timescale 1ns/100ps
`default_nettype none

module i2s_transmitter import i2s_tx_pkg::*; (
  input  logic      aud_mclk,
  input  logic      PRESETn,
  input  logic      PSEL,
  input  logic      PENABLE,
  input  logic      PWRITE,
  input  apb_addr_t PADDR,
  input  apb_data_t PWDATA,
  output apb_data_t PRDATA,
  output logic      PREADY,
  output logic      PSLVERR,
  output logic      irq,
  output logic      fifo_full,
  output logic      lrclk_out,
  output logic      sclk_out,
  output logic      sdata_out
);

  logic         enable;
  clk_div_t     clk_div;
  sample_bits_t sample_bits;
  logic         fifo_wr;
  sample_t      fifo_wdata;
  logic         fifo_flush;
  logic         fifo_empty;
  sample_t      fifo_head;
  logic         pop;
  logic         bit_tick;
  logic         tx_idle;

  // zero wait state, no errors
  assign PREADY  = 1'b1;
  assign PSLVERR = 1'b0;

  i2s_apb_regs u_regs (
    .aud_mclk, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
    .full        (fifo_full),
    .empty       (fifo_empty),
    .tx_idle,
    .PRDATA, .irq, .enable, .clk_div, .sample_bits,
    .fifo_wr, .fifo_wdata, .fifo_flush
  );

  i2s_sample_fifo u_fifo (
    .aud_mclk, .PRESETn,
    .wr    (fifo_wr),
    .wdata (fifo_wdata),
    .pop,
    .flush (fifo_flush),
    .head  (fifo_head),
    .full  (fifo_full),
    .empty (fifo_empty)
  );

  i2s_bclk_gen u_bclk (
    .aud_mclk, .PRESETn, .enable, .clk_div, .sclk_out, .bit_tick
  );

  i2s_serializer u_ser (
    .aud_mclk, .PRESETn, .enable, .bit_tick, .sample_bits,
    .head  (fifo_head),
    .empty (fifo_empty),
    .pop, .lrclk_out, .sdata_out, .tx_idle
  );

endmodule

`default_nettype wire

/* test/tb_i2s_transmitter.sv */
`timescale 1ns/100ps
`default_nettype none
`include "i2s_tx_params.svh"

module tb_i2s_transmitter import i2s_tx_pkg::*; ();

  localparam int NROWS = 4;
  localparam int TMO   = 5000;  // mclk cycles per wait
  localparam int W_RX  = 0;     // wait selectors
  localparam int W_IRQ = 1;

  typedef struct {
    string   name;
    int      bits;
    int      div;
    sample_t left;
    sample_t right;
  } row_t;

  logic      aud_mclk;
  logic      PRESETn;
  logic      PSEL;
  logic      PENABLE;
  logic      PWRITE;
  apb_addr_t PADDR;
  apb_data_t PWDATA;
  apb_data_t PRDATA;
  logic      PREADY;
  logic      PSLVERR;
  logic      irq;
  logic      fifo_full;
  logic      lrclk_out;
  logic      sclk_out;
  logic      sdata_out;

  row_t    rows [NROWS];
  int      err_cnt;
  int      timeout_cnt;
  // receiver model state
  int      rx_bits;
  int      rx_l_cnt;
  int      rx_r_cnt;
  sample_t rx_left;
  sample_t rx_right;
  realtime last_rise;
  realtime sclk_period;

  i2s_transmitter dut0 (.*);

  initial begin
    aud_mclk = 1'b0;
    forever #5 aud_mclk = ~aud_mclk;  // 100 MHz
  end

  // left word while lrclk low, then right word while high, msb first
  always @(posedge sclk_out) begin
    sclk_period = $realtime - last_rise;
    last_rise   = $realtime;
    if (!lrclk_out && rx_l_cnt < rx_bits) begin
      rx_left  = {rx_left[30:0], sdata_out};
      rx_l_cnt = rx_l_cnt + 1;
    end else if (lrclk_out && rx_l_cnt == rx_bits && rx_r_cnt < rx_bits) begin
      rx_right = {rx_right[30:0], sdata_out};
      rx_r_cnt = rx_r_cnt + 1;
    end
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  // low bits of the word that go on the wire
  function automatic sample_t wire_bits(input sample_t w, input int bits);
    if (bits >= 32) return w;
    return w & ((32'h1 << bits) - 32'h1);
  endfunction

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(posedge aud_mclk);
    PSEL    <= 1'b1;  // setup
    PENABLE <= 1'b0;
    PWRITE  <= 1'b1;
    PADDR   <= addr;
    PWDATA  <= data;
    @(posedge aud_mclk);
    PENABLE <= 1'b1;  // access, commits at the next edge
    @(posedge aud_mclk);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    @(posedge aud_mclk);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
    PADDR   <= addr;
    @(posedge aud_mclk);
    PENABLE <= 1'b1;
    @(negedge aud_mclk);
    data = PRDATA;  // mid access phase
    check("pready", 32'h1, 32'(PREADY));  // zero wait state slave
    check("pslverr", 32'h0, 32'(PSLVERR));
    @(posedge aud_mclk);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  function automatic logic cond_met(input int what);
    case (what)
      W_RX:    return rx_r_cnt >= rx_bits;
      W_IRQ:   return irq;
      default: return 1'b1;
    endcase
  endfunction

  task automatic wait_for(input int what, input string name);
    int n;
    n = 0;
    while (!cond_met(what) && n < TMO) begin
      @(negedge aud_mclk);
      n++;
    end
    if (!cond_met(what)) begin
      $display("timeout in %s, condition %0d never came true", name, what);
      timeout_cnt++;
    end
  endtask

  // poll status until the serializer is parked with the fifo empty
  task automatic wait_drained(input string name, output apb_data_t st);
    int n;
    n = 0;
    apb_read(`I2S_REG_STATUS, st);
    while (!st[3] && n < TMO) begin
      apb_read(`I2S_REG_STATUS, st);
      n++;
    end
    if (!st[3]) begin
      $display("timeout in %s, status never showed tx_complete", name);
      timeout_cnt++;
    end
  endtask

  task automatic rx_clear(input int bits);
    rx_bits  = bits;
    rx_l_cnt = 0;
    rx_r_cnt = 0;
    rx_left  = '0;
    rx_right = '0;
  endtask

  // one stereo frame through the whole path
  task automatic run_row(input row_t r);
    apb_data_t st;
    apb_write(`I2S_REG_ENABLE, 0);
    apb_write(`I2S_REG_CLKDIV, r.div);
    apb_write(`I2S_REG_BITS, r.bits);
    apb_write(`I2S_REG_FIFO, r.left);
    apb_write(`I2S_REG_FIFO, r.right);
    rx_clear(r.bits);  // sclk parked, safe
    apb_write(`I2S_REG_ENABLE, 1);
    wait_for(W_RX, r.name);
    check({r.name, "_left"}, wire_bits(r.left, r.bits), rx_left);
    check({r.name, "_right"}, wire_bits(r.right, r.bits), rx_right);
    check({r.name, "_sclk_period"}, 32'(20 * r.div), 32'($rtoi(sclk_period)));
    wait_drained({r.name, "_drain"}, st);  // underrun parks the serializer
    check({r.name, "_tx_complete"}, 32'h1, 32'(st[3]));
    check({r.name, "_lrclk_idle"}, 32'h1, 32'(lrclk_out));
  endtask

  initial begin
    apb_data_t rd;
    sample_t   n0;
    sample_t   n1;
    int        highs;
    PRESETn = 1'b0;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    err_cnt     = 0;
    timeout_cnt = 0;
    last_rise   = 0.0;
    sclk_period = 0.0;
    rx_clear(0);
    void'($urandom(32'h0ac1_de55));
    rows[0] = '{"w16_div2", 16, 2, $urandom, $urandom};
    rows[1] = '{"w24_div3", 24, 3, $urandom, $urandom};
    rows[2] = '{"w32_div2", 32, 2, $urandom, $urandom};
    rows[3] = '{"w16_div4", 16, 4, $urandom, $urandom};
    n0 = $urandom;
    n1 = $urandom;

    repeat (10) @(posedge aud_mclk);
    PRESETn <= 1'b1;
    repeat (2) @(posedge aud_mclk);

    // reset values
    apb_read(`I2S_REG_ENABLE, rd);
    check("rst_enable", 32'h0, rd);
    apb_read(`I2S_REG_CLKDIV, rd);
    check("rst_clkdiv", 32'(`I2S_CLKDIV_RST), rd);
    apb_read(`I2S_REG_BITS, rd);
    check("rst_bits", 32'(`I2S_BITS_RST), rd);
    apb_read(`I2S_REG_STATUS, rd);
    check("rst_status", 32'h0000_000A, rd);  // complete, not-full
    @(negedge aud_mclk);
    check("rst_irq", 32'h0, 32'(irq));
    check("rst_lrclk", 32'h1, 32'(lrclk_out));
    check("rst_sclk", 32'h0, 32'(sclk_out));
    check("rst_sdata", 32'h0, 32'(sdata_out));

    // read-back, illegal values keep the old ones
    apb_write(`I2S_REG_CLKDIV, 5);
    apb_read(`I2S_REG_CLKDIV, rd);
    check("rw_clkdiv", 32'd5, rd);
    apb_write(`I2S_REG_BITS, 24);
    apb_read(`I2S_REG_BITS, rd);
    check("rw_bits", 32'd24, rd);
    apb_write(`I2S_REG_BITS, 20);
    apb_read(`I2S_REG_BITS, rd);
    check("rw_bits_illegal", 32'd24, rd);
    apb_write(`I2S_REG_CLKDIV, 0);
    apb_read(`I2S_REG_CLKDIV, rd);
    check("rw_clkdiv_zero", 32'd5, rd);

    for (int i = 0; i < NROWS; i++) begin
      run_row(rows[i]);
    end

    // disabled core keeps sclk quiet
    apb_write(`I2S_REG_ENABLE, 0);
    highs = 0;
    repeat (100) begin
      @(negedge aud_mclk);
      if (sclk_out) highs++;
    end
    check("disable_sclk_low", 32'h0, 32'(highs));

    // overfill, then flush
    for (int i = 0; i <= `I2S_FIFO_DEPTH; i++) begin
      apb_write(`I2S_REG_FIFO, $urandom);
    end
    apb_read(`I2S_REG_STATUS, rd);
    check("full_status", 32'h0000_0005, rd);
    check("full_port", 32'h1, 32'(fifo_full));
    apb_write(`I2S_REG_FIFO_RST, 1);
    apb_read(`I2S_REG_STATUS, rd);
    check("flush_status", 32'h0000_000A, rd);
    apb_write(`I2S_REG_FIFO, n0);
    apb_write(`I2S_REG_FIFO, n1);
    rx_clear(rows[NROWS-1].bits);
    apb_write(`I2S_REG_ENABLE, 1);
    wait_for(W_RX, "flush_rx");
    check("flush_left", wire_bits(n0, rows[NROWS-1].bits), rx_left);
    check("flush_right", wire_bits(n1, rows[NROWS-1].bits), rx_right);
    wait_drained("flush_drain", rd);
    apb_write(`I2S_REG_ENABLE, 0);

    // interrupt needs both enables
    apb_write(`I2S_REG_IRQ_EN, 1);
    @(negedge aud_mclk);
    check("irq_core_off", 32'h0, 32'(irq));
    apb_write(`I2S_REG_ENABLE, 1);
    wait_for(W_IRQ, "irq_rise");
    apb_read(`I2S_REG_IRQ_PEND, rd);
    check("irq_pend", 32'h1, rd);
    apb_read(`I2S_REG_STATUS, rd);  // acks by clearing irq_en
    @(negedge aud_mclk);
    check("irq_after_status", 32'h0, 32'(irq));
    apb_read(`I2S_REG_IRQ_EN, rd);
    check("irq_en_cleared", 32'h0, rd);
    apb_write(`I2S_REG_ENABLE, 0);

    $display("closing: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+src
src/i2s_tx_pkg.sv
src/i2s_apb_regs.sv
src/i2s_sample_fifo.sv
src/i2s_bclk_gen.sv
src/i2s_serializer.sv
src/i2s_transmitter.sv
test/tb_i2s_transmitter.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_i2s_transmitter
FILELIST  = tb.f

.PHONY: sim clean

# build, run, and pass only if the pass line shows up
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir
